// ==== ps2_keypad.f ====
verilog/ps2_keypad_pkg.sv
verilog/ps2_transceiver.sv
verilog/keypad_decoder.sv
verilog/keypad_regs.sv
verilog/ps2_keypad.sv
tb/ps2_device_model.sv
tb/tb_ps2_keypad.sv

// ==== Bender.yml ====
package:
  name: ps2_keypad

sources:
  - verilog/ps2_keypad_pkg.sv
  - verilog/ps2_transceiver.sv
  - verilog/keypad_decoder.sv
  - verilog/keypad_regs.sv
  - verilog/ps2_keypad.sv
  - target: test
    files:
      - tb/ps2_device_model.sv
      - tb/tb_ps2_keypad.sv

// ==== tb/tb_ps2_keypad.sv ====
`timescale 1ns/1ps

module tb_ps2_keypad import ps2_keypad_pkg::*; ();

  localparam int half_period = 20;
  localparam int max_cycles  = 400_000;   // ~250 frames of ~480 cycles, about 3x margin

  // hex pad codes first, then letters that have no mapping
  localparam logic [23:0][7:0] key_table = {
    8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D,
    8'h3E, 8'h46, 8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B,
    8'h15, 8'h1D, 8'h2D, 8'h2C, 8'h35, 8'h3C, 8'h43, 8'h44
  };

  typedef struct packed {
    key_code_t code;
    logic      brk;
    logic      mapped;
  } key_event_t;

  logic        clk = 1'b0;
  logic        reset;
  wire         ps2_clk;
  wire         ps2_data;
  logic        key_valid;
  logic        key_ready;
  key_code_t   key_code;
  logic        key_break;
  logic        key_mapped;
  logic        cfg_write;
  cfg_addr_t   cfg_addr;
  logic [7:0]  cfg_wdata;
  logic [7:0]  cfg_rdata;
  int          frames_sent;
  int          acks_sent;
  int          cmd_errors;

  key_event_t  exp_q[$];
  ps2_byte_t   held;         // reference state
  logic        brk_pend;
  logic        scan_en;
  logic [1:0]  ready_mode;   // 0 ready, 1 stalled, 2 random
  logic [31:0] rng;
  int          checks;
  int          errors;
  int          cycles = 0;

  pullup (ps2_clk);
  pullup (ps2_data);

  always #5 clk = ~clk;

  ps2_keypad #(
    .FILTER_LEN     (4),
    .INHIBIT_CYCLES (100)
  ) i_ps2_keypad (
    .clk, .reset, .ps2_clk, .ps2_data,
    .key_valid, .key_ready, .key_code, .key_break, .key_mapped,
    .cfg_write, .cfg_addr, .cfg_wdata, .cfg_rdata
  );

  ps2_device_model #(.HALF_PERIOD(half_period)) i_device (
    .clk, .ps2_clk, .ps2_data, .frames_sent, .acks_sent, .cmd_errors
  );

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // one received byte against the break and repeat rules
  function automatic logic expected_event(input ps2_byte_t b, inout ps2_byte_t held_key,
                                          inout logic brk, output key_event_t ev);
    key_code_t c;
    ev = '0;
    if (b == code_bat_ok) begin
      held_key = '0;
      return 1'b0;
    end
    if (b == code_break) begin
      brk = 1'b1;
      return 1'b0;
    end
    if (!brk && (b == code_ack || b == held_key)) begin
      return 1'b0;                          // typematic repeat gives nothing
    end
    ev.mapped = keypad_map(b, c);
    ev.code   = c;
    ev.brk    = brk;
    if (brk && b == held_key) begin
      held_key = '0;
    end else if (!brk) begin
      held_key = b;
    end
    brk = 1'b0;
    return 1'b1;
  endfunction

  // --------------------
  // compare tasks
  // --------------------
  task automatic record_check(input logic ok, input string what, input logic [7:0] got,
                              input logic [7:0] exp);
    checks++;
    if (!ok) begin
      errors++;
      $display("ERR %0t: %s is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_key(input key_code_t got, input key_code_t exp, input string what);
    record_check(got === exp, what, got, exp);
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    record_check(got === exp, what, {7'b0, got}, {7'b0, exp});
  endtask

  task automatic check_byte(input ps2_byte_t got, input ps2_byte_t exp, input string what);
    record_check(got === exp, what, got, exp);
  endtask

  task automatic check_count(input err_count_t got, input err_count_t exp, input string what);
    record_check(got === exp, what, got, exp);
  endtask

  // --------------------
  // stimulus helpers
  // --------------------
  task automatic send_key(input ps2_byte_t b);
    key_event_t ev;
    if (expected_event(b, held, brk_pend, ev) && scan_en) begin
      exp_q.push_back(ev);
    end
    i_device.send_byte(b, 1'b0);
  endtask

  task automatic write_reg(input cfg_addr_t addr, input logic [7:0] data);
    @(posedge clk);
    #1;
    cfg_write = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);
    #1;
    cfg_write = 1'b0;
  endtask

  task automatic read_reg(input cfg_addr_t addr, output logic [7:0] data);
    @(posedge clk);
    #1;
    cfg_addr = addr;
    @(posedge clk);
    #1;
    data = cfg_rdata;
  endtask

  task automatic wait_acks(input int n);
    while (acks_sent < n) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);             // ack byte reaches the decoder
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || key_valid) && n < 20000) begin
      @(posedge clk);
      n++;
    end
    if (n == 20000) begin
      errors++;
      $display("key events missing, %0d still expected", exp_q.size());
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errors_before);
    end
  endtask

  always @(posedge clk) begin
    #1;
    case (ready_mode)
      2'd0:    key_ready = 1'b1;
      2'd1:    key_ready = 1'b0;
      default: key_ready = (xorshift() % 4) != 0;
    endcase
  end

  // key stream monitor
  always @(posedge clk) begin
    key_event_t head;
    if (!reset && key_valid && key_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERR %0t: unexpected key event %02h", $time, key_code);
      end else begin
        head = exp_q.pop_front();
        check_key(key_code, head.code, "key code");
        check_flag(key_break, head.brk, "key break");
        check_flag(key_mapped, head.mapped, "key mapped");
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles == max_cycles) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  // --------------------
  // tests
  // --------------------
  initial begin
    int         e0;
    int         base;
    logic [7:0] rdata;
    ps2_byte_t  code;
    reset      = 1'b1;
    key_ready  = 1'b1;
    cfg_write  = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    ready_mode = 2'd0;
    rng        = 32'd89;
    checks     = 0;
    errors     = 0;
    held       = '0;
    brk_pend   = 1'b0;
    scan_en    = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (10) @(posedge clk);

    e0 = errors;
    send_key(code_bat_ok);
    wait_acks(1);
    check_count(i_device.cmd_count(), 8'd1, "command count");
    check_byte(i_device.pop_cmd(), cmd_enable, "enable command");
    end_test("self test", e0);

    e0 = errors;
    ready_mode = 2'd2;
    repeat (40) begin
      code = key_table[xorshift() % 24];
      send_key(code);
      send_key(code_break);
      send_key(code);
    end
    wait_drain();
    end_test("random keys", e0);

    e0 = errors;
    for (int pass = 0; pass < 2; pass++) begin
      repeat (5) send_key(8'h1C);
      send_key(code_break);
      send_key(8'h1C);
      wait_drain();
      write_reg(2'd0, {7'b0, pass[0]});       // off for the second pass, on again after it
      scan_en = pass[0];
    end
    end_test("repeat and scan enable", e0);

    e0 = errors;
    base = acks_sent;
    write_reg(2'd1, 8'h03);
    wait_acks(base + 2);
    check_byte(i_device.pop_cmd(), cmd_set_led, "led command");
    check_byte(i_device.pop_cmd(), 8'h03, "led value");
    send_key(code_caps);
    wait_acks(base + 4);
    check_byte(i_device.pop_cmd(), cmd_set_led, "caps led command");
    check_byte(i_device.pop_cmd(), 8'h07, "caps led value");
    send_key(code_break);
    send_key(code_caps);
    wait_drain();
    read_reg(2'd1, rdata);
    check_count(rdata, 8'h07, "led register");
    end_test("led commands", e0);

    e0 = errors;
    ready_mode = 2'd1;
    repeat (4) @(posedge clk);
    base = frames_sent;
    fork
      repeat (4) begin
        code = key_table[xorshift() % 24];
        send_key(code);
        send_key(code_break);
        send_key(code);
      end
      begin
        wait (frames_sent >= base + 2);
        repeat (2000) @(posedge clk);
        #1;
        checks++;
        if (frames_sent != base + 2 || ps2_clk !== 1'b0) begin
          errors++;
          $display("ERR %0t: keyboard not held off, %0d frames sent", $time, frames_sent - base);
        end
        ready_mode = 2'd2;
      end
    join
    wait_drain();
    end_test("back-pressure", e0);

    e0 = errors;
    repeat (3) i_device.send_byte(8'h16, 1'b1);
    repeat (20) @(posedge clk);
    read_reg(2'd2, rdata);
    check_count(rdata, 8'd3, "error count");
    end_test("bad parity", e0);

    if (cmd_errors != 0) begin
      errors++;
      $display("keyboard received %0d host commands with bad parity or stop bit", cmd_errors);
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== tb/ps2_device_model.sv ====
`timescale 1ns/1ps

module ps2_device_model import ps2_keypad_pkg::*; #(
  parameter int HALF_PERIOD = 20   // clk cycles per half PS/2 clock
) (
  input  logic clk,
  inout  wire  ps2_clk,
  inout  wire  ps2_data,
  output int   frames_sent,
  output int   acks_sent,
  output int   cmd_errors
);

  logic      clk_oe  = 1'b0;
  logic      data_oe = 1'b0;
  logic      busy    = 1'b0;   // keyboard owns the line
  ps2_byte_t cmd_q[$];

  assign ps2_clk  = clk_oe  ? 1'b0 : 1'bz;
  assign ps2_data = data_oe ? 1'b0 : 1'bz;

  initial begin
    frames_sent = 0;
    acks_sent   = 0;
    cmd_errors  = 0;
  end

  function automatic int cmd_count();
    return cmd_q.size();
  endfunction

  function automatic ps2_byte_t pop_cmd();
    return cmd_q.pop_front();
  endfunction

  task automatic half_wait();
    repeat (HALF_PERIOD) @(posedge clk);
    #1;
  endtask

  // --------------------
  // device to host
  // --------------------
  task automatic send_frame(input ps2_byte_t b, input logic bad_parity);
    logic [10:0] frame;
    frame = {1'b1, (~^b) ^ bad_parity, b, 1'b0};   // stop, odd parity, data, start
    for (int i = 0; i < 11; i++) begin
      data_oe = ~frame[i];
      half_wait();
      clk_oe = 1'b1;
      half_wait();
      clk_oe = 1'b0;
    end
    data_oe = 1'b0;
    frames_sent++;
  endtask

  // line must stay released for a full clock period, so an inhibit holds us off
  task automatic wait_line_idle();
    int quiet;
    quiet = 0;
    while (quiet < 2 * HALF_PERIOD) begin
      @(posedge clk);
      #1;
      if (busy || ps2_clk !== 1'b1 || ps2_data !== 1'b1) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
  endtask

  task automatic send_byte(input ps2_byte_t b, input logic bad_parity);
    wait_line_idle();
    busy = 1'b1;
    send_frame(b, bad_parity);
    busy = 1'b0;
  endtask

  // --------------------
  // host to device
  // --------------------
  task automatic receive_command();
    logic [9:0] bits;
    half_wait();
    for (int i = 0; i < 10; i++) begin
      clk_oe = 1'b1;
      half_wait();
      clk_oe = 1'b0;
      bits[i] = ps2_data;                     // host changed data on the falling edge
      half_wait();
    end
    data_oe = 1'b1;                           // line acknowledge
    clk_oe  = 1'b1;
    half_wait();
    clk_oe  = 1'b0;
    data_oe = 1'b0;
    if (!(^bits[8:0]) || !bits[9]) begin
      cmd_errors++;
    end
    cmd_q.push_back(bits[7:0]);
    half_wait();
    send_frame(code_ack, 1'b0);
    acks_sent++;
  endtask

  always begin
    @(negedge ps2_clk);
    if (!busy) begin
      busy = 1'b1;
      while (ps2_clk !== 1'b1) begin
        @(posedge clk);
        #1;
      end
      if (ps2_data === 1'b0) begin            // request to send, else a plain inhibit
        receive_command();
      end
      busy = 1'b0;
    end
  end

endmodule

// ==== verilog/ps2_keypad.sv ====
`timescale 1ns/1ps

module ps2_keypad import ps2_keypad_pkg::*; #(
  parameter int FILTER_LEN     = 8,
  parameter int INHIBIT_CYCLES = 5000
) (
  input  logic       clk,
  input  logic       reset,
  inout  wire        ps2_clk,
  inout  wire        ps2_data,
  output logic       key_valid,
  input  logic       key_ready,
  output key_code_t  key_code,
  output logic       key_break,
  output logic       key_mapped,
  input  logic       cfg_write,
  input  cfg_addr_t  cfg_addr,
  input  logic [7:0] cfg_wdata,
  output logic [7:0] cfg_rdata
);

  logic      rx_valid;
  logic      rx_ready;
  ps2_byte_t rx_data;
  logic      rx_error;
  logic      tx_valid;
  logic      tx_ready;
  ps2_byte_t tx_data;
  logic      scan_enable;
  logic      led_request;
  logic      led_done;
  logic      caps_toggle;
  led_t      led;

  ps2_transceiver #(
    .FILTER_LEN     (FILTER_LEN),
    .INHIBIT_CYCLES (INHIBIT_CYCLES)
  ) i_ps2_transceiver (
    .clk, .reset, .ps2_clk, .ps2_data,
    .rx_valid, .rx_ready, .rx_data, .rx_error,
    .tx_valid, .tx_ready, .tx_data
  );

  keypad_decoder i_keypad_decoder (
    .clk, .reset,
    .rx_valid, .rx_ready, .rx_data,
    .tx_valid, .tx_ready, .tx_data,
    .key_valid, .key_ready, .key_code, .key_break, .key_mapped,
    .scan_enable, .led_request, .led, .led_done, .caps_toggle
  );

  keypad_regs i_keypad_regs (
    .clk, .reset,
    .cfg_write, .cfg_addr, .cfg_wdata, .cfg_rdata,
    .rx_error, .caps_toggle, .led_done,
    .scan_enable, .led, .led_request
  );

endmodule

// ==== verilog/keypad_regs.sv ====
`timescale 1ns/1ps

module keypad_regs import ps2_keypad_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       cfg_write,
  input  cfg_addr_t  cfg_addr,
  input  logic [7:0] cfg_wdata,
  output logic [7:0] cfg_rdata,
  input  logic       rx_error,
  input  logic       caps_toggle,
  input  logic       led_done,
  output logic       scan_enable,
  output led_t       led,
  output logic       led_request
);

  localparam cfg_addr_t addr_ctrl   = 2'd0;
  localparam cfg_addr_t addr_led    = 2'd1;
  localparam cfg_addr_t addr_errors = 2'd2;   // read only

  led_t       led_next;
  logic       led_change;
  logic       led_again;   // value moved while a command pair was pending
  err_count_t err_count;

  always_comb begin
    led_next = led;
    if (cfg_write && cfg_addr == addr_led) begin
      led_next = cfg_wdata[2:0];
    end
    if (caps_toggle) begin
      led_next[2] = ~led_next[2];
    end
  end

  assign led_change = (led_next != led);

  always_ff @(posedge clk) begin
    if (reset) begin
      scan_enable <= 1'b1;
      led         <= '0;
      led_request <= 1'b0;
      led_again   <= 1'b0;
      err_count   <= '0;
    end else begin
      led <= led_next;
      if (cfg_write && cfg_addr == addr_ctrl) begin
        scan_enable <= cfg_wdata[0];
      end
      if (rx_error && err_count != '1) begin
        err_count <= err_count + 1'b1;         // saturates
      end
      if (led_done) begin
        led_request <= led_again || led_change;
        led_again   <= 1'b0;
      end else if (led_change) begin
        led_request <= 1'b1;
        led_again   <= led_request;
      end
    end
  end

  always_ff @(posedge clk) begin
    case (cfg_addr)
      addr_ctrl:   cfg_rdata <= {7'b0, scan_enable};
      addr_led:    cfg_rdata <= {5'b0, led};
      addr_errors: cfg_rdata <= err_count;
      default:     cfg_rdata <= '0;
    endcase
  end

endmodule

// ==== verilog/keypad_decoder.sv ====
`timescale 1ns/1ps

module keypad_decoder import ps2_keypad_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      rx_valid,
  output logic      rx_ready,
  input  ps2_byte_t rx_data,
  output logic      tx_valid,
  input  logic      tx_ready,
  output ps2_byte_t tx_data,
  output logic      key_valid,
  input  logic      key_ready,
  output key_code_t key_code,
  output logic      key_break,
  output logic      key_mapped,
  input  logic      scan_enable,
  input  logic      led_request,
  input  led_t      led,
  output logic      led_done,
  output logic      caps_toggle
);

  typedef enum logic [3:0] {
    st_idle,
    st_break_pending,
    st_ext_pending,
    st_send_enable,
    st_wait_ack,
    st_send_led_cmd,
    st_wait_led_ack,
    st_send_led_value,
    st_wait_value_ack
  } state_t;

  state_t    state;
  ps2_byte_t held_code;   // key currently down, 0 when none
  key_code_t map_code;
  logic      map_hit;
  logic      rx_fire;
  logic      rx_is_ack;

  assign rx_ready  = !(key_valid && !key_ready);
  assign rx_fire   = rx_valid && rx_ready;
  assign rx_is_ack = rx_fire && (rx_data == code_ack);

  always_comb begin
    map_hit = keypad_map(rx_data, map_code);
  end

  // same cycle as the return to idle, so the request is gone on the next one
  assign led_done = (state == st_wait_value_ack) && rx_is_ack;

  always_comb begin
    tx_valid = 1'b0;
    tx_data  = cmd_enable;
    case (state)
      st_send_enable: tx_valid = 1'b1;
      st_send_led_cmd: begin
        tx_valid = 1'b1;
        tx_data  = cmd_set_led;
      end
      st_send_led_value: begin
        tx_valid = 1'b1;
        tx_data  = {5'b0, led};
      end
      default: tx_valid = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= st_idle;
      held_code   <= '0;
      key_valid   <= 1'b0;
      caps_toggle <= 1'b0;
    end else begin
      caps_toggle <= 1'b0;
      if (key_valid && key_ready) begin
        key_valid <= 1'b0;
      end
      case (state)
        st_idle: begin
          if (rx_fire) begin
            if (rx_data == code_bat_ok) begin
              held_code <= '0;                   // keyboard restarted
              state     <= st_send_enable;
            end else if (rx_data == code_break) begin
              state <= st_break_pending;
            end else if (rx_data == code_ext) begin
              state <= st_ext_pending;
            end else if (rx_data != code_ack && rx_data != held_code) begin
              held_code   <= rx_data;            // later repeats give no event
              caps_toggle <= (rx_data == code_caps);
              if (scan_enable) begin
                key_valid  <= 1'b1;
                key_code   <= map_code;
                key_break  <= 1'b0;
                key_mapped <= map_hit;
              end
            end
          end else if (led_request) begin
            state <= st_send_led_cmd;
          end
        end
        st_break_pending: begin
          if (rx_fire) begin
            if (rx_data == held_code) begin
              held_code <= '0;
            end
            if (scan_enable) begin
              key_valid  <= 1'b1;
              key_code   <= map_code;
              key_break  <= 1'b1;
              key_mapped <= map_hit;
            end
            state <= st_idle;
          end
        end
        st_ext_pending: begin
          if (rx_fire && rx_data != code_break) begin
            state <= st_idle;                    // E0 codes are dropped
          end
        end
        st_send_enable:    if (tx_ready) state <= st_wait_ack;
        st_wait_ack:       if (rx_is_ack) state <= st_idle;
        st_send_led_cmd:   if (tx_ready) state <= st_wait_led_ack;
        st_wait_led_ack:   if (rx_is_ack) state <= st_send_led_value;
        st_send_led_value: if (tx_ready) state <= st_wait_value_ack;
        st_wait_value_ack: if (rx_is_ack) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== verilog/ps2_transceiver.sv ====
`timescale 1ns/1ps

module ps2_transceiver import ps2_keypad_pkg::*; #(
  parameter int FILTER_LEN     = 8,
  parameter int INHIBIT_CYCLES = 5000
) (
  input  logic      clk,
  input  logic      reset,
  inout  wire       ps2_clk,
  inout  wire       ps2_data,
  output logic      rx_valid,
  input  logic      rx_ready,
  output ps2_byte_t rx_data,
  output logic      rx_error,
  input  logic      tx_valid,
  output logic      tx_ready,
  input  ps2_byte_t tx_data
);

  localparam int FILT_W  = $clog2(FILTER_LEN + 1);
  localparam int TIMER_W = $clog2(INHIBIT_CYCLES + 1);

  typedef enum logic [2:0] {
    st_idle,
    st_receive,
    st_inhibit,
    st_transmit,
    st_line_ack,
    st_hold
  } state_t;

  state_t             state;
  logic [1:0]         clk_sync;
  logic [1:0]         data_sync;
  logic               clk_filt;
  logic               clk_filt_q;
  logic [FILT_W-1:0]  filt_cnt;
  logic               clk_fall;
  logic               clk_oe;
  logic               data_oe;
  logic [3:0]         bit_cnt;
  logic [9:0]         rx_shift;
  logic [10:0]        frame;
  logic               frame_ok;
  logic [9:0]         tx_shift;
  logic [TIMER_W-1:0] timer;

  assign ps2_clk  = clk_oe  ? 1'b0 : 1'bz;   // open drain
  assign ps2_data = data_oe ? 1'b0 : 1'bz;

  // --------------------
  // line conditioning
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      clk_sync   <= 2'b11;
      data_sync  <= 2'b11;
      clk_filt   <= 1'b1;
      clk_filt_q <= 1'b1;
      filt_cnt   <= '0;
    end else begin
      clk_sync   <= {clk_sync[0], ps2_clk};
      data_sync  <= {data_sync[0], ps2_data};
      clk_filt_q <= clk_filt;
      if (clk_sync[1] == clk_filt) begin
        filt_cnt <= '0;
      end else if (filt_cnt == FILT_W'(FILTER_LEN - 1)) begin
        filt_cnt <= '0;
        clk_filt <= clk_sync[1];               // level stable long enough
      end else begin
        filt_cnt <= filt_cnt + 1'b1;
      end
    end
  end

  assign clk_fall = clk_filt_q & ~clk_filt;

  // start, 8 data bits, odd parity, stop
  assign frame    = {data_sync[1], rx_shift};
  assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

  assign tx_ready = (state == st_idle) && !rx_valid && clk_filt && clk_sync[1];

  // --------------------
  // frame FSM
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      rx_valid <= 1'b0;
      rx_error <= 1'b0;
      clk_oe   <= 1'b0;
      data_oe  <= 1'b0;
      bit_cnt  <= '0;
      timer    <= '0;
    end else begin
      rx_error <= 1'b0;
      if (rx_valid && rx_ready) begin
        rx_valid <= 1'b0;
      end
      case (state)
        st_idle: begin
          if (rx_valid && !rx_ready) begin
            clk_oe <= 1'b1;                      // inhibit the keyboard
            state  <= st_hold;
          end else if (tx_valid && tx_ready) begin
            tx_shift <= {1'b1, ~^tx_data, tx_data};
            timer    <= '0;
            clk_oe   <= 1'b1;
            state    <= st_inhibit;
          end else if (clk_fall) begin
            rx_shift <= {data_sync[1], rx_shift[9:1]};
            bit_cnt  <= 4'd1;
            state    <= st_receive;
          end
        end
        st_receive: begin
          if (clk_fall) begin
            if (bit_cnt == 4'd10) begin
              state <= st_idle;
              if (frame_ok) begin
                rx_valid <= 1'b1;
                rx_data  <= frame[8:1];
              end else begin
                rx_error <= 1'b1;
              end
            end else begin
              rx_shift <= {data_sync[1], rx_shift[9:1]};
              bit_cnt  <= bit_cnt + 1'b1;
            end
          end
        end
        st_inhibit: begin
          timer <= timer + 1'b1;
          if (timer == TIMER_W'(INHIBIT_CYCLES - 1)) begin
            data_oe <= 1'b1;                     // request to send
          end
          if (timer == TIMER_W'(INHIBIT_CYCLES)) begin
            clk_oe  <= 1'b0;
            bit_cnt <= '0;
            state   <= st_transmit;
          end
        end
        st_transmit: begin
          if (clk_fall) begin
            data_oe  <= ~tx_shift[0];            // device samples on the rising edge
            tx_shift <= {1'b1, tx_shift[9:1]};
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd9) begin
              state <= st_line_ack;
            end
          end
        end
        st_line_ack: begin
          if (clk_fall) begin
            state <= st_idle;                    // ack bit clocked by the device
          end
        end
        st_hold: begin
          if (rx_ready || !rx_valid) begin
            clk_oe <= 1'b0;
          end
          // back to idle once the released clock has settled high
          if (!clk_oe && clk_sync[1] && clk_filt) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== verilog/ps2_keypad_pkg.sv ====
package ps2_keypad_pkg;

  typedef logic [7:0] ps2_byte_t;
  typedef logic [7:0] key_code_t;
  typedef logic [2:0] led_t;        // scroll, num, caps
  typedef logic [7:0] err_count_t;
  typedef logic [1:0] cfg_addr_t;

  localparam ps2_byte_t code_bat_ok = 8'hAA;  // self-test passed
  localparam ps2_byte_t code_ack    = 8'hFA;
  localparam ps2_byte_t code_break  = 8'hF0;
  localparam ps2_byte_t code_ext    = 8'hE0;
  localparam ps2_byte_t code_caps   = 8'h58;
  localparam ps2_byte_t cmd_enable  = 8'hF4;
  localparam ps2_byte_t cmd_set_led = 8'hED;

  // hex pad lookup, unmapped codes come back unchanged with a low flag
  function automatic logic keypad_map(input ps2_byte_t scan, output key_code_t code);
    logic mapped;
    mapped = 1'b1;
    code   = scan;
    case (scan)
      8'h45: code = 8'h00;
      8'h16: code = 8'h01;
      8'h1E: code = 8'h02;
      8'h26: code = 8'h03;
      8'h25: code = 8'h04;
      8'h2E: code = 8'h05;
      8'h36: code = 8'h06;
      8'h3D: code = 8'h07;
      8'h3E: code = 8'h08;
      8'h46: code = 8'h09;
      8'h1C: code = 8'h0A;
      8'h32: code = 8'h0B;
      8'h21: code = 8'h0C;
      8'h23: code = 8'h0D;
      8'h24: code = 8'h0E;
      8'h2B: code = 8'h0F;
      default: mapped = 1'b0;
    endcase
    return mapped;
  endfunction

endpackage
